//--- all.f
rtl/ic_pref_pkg.sv
rtl/ic_pref_req_decode.sv
rtl/ic_pref_engine.sv
rtl/ic_pref_buffer.sv
rtl/ic_pref_top.sv
testbench/ic_pref_chk.sv
testbench/ic_pref_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ic_pref_tb
FILELIST  = all.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- testbench/ic_pref_tb.sv
// Testbench for the next-line instruction prefetcher
// Random fetch traffic with L2 and I-cache models, checked against a cycle model

`timescale 1ns/1ns

module ic_pref_tb;

  import ic_pref_pkg::*;

  localparam int          NUM_CYCLES     = 3000;
  localparam int          RESET_CYCLES   = 10;
  localparam int          TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 3;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
  localparam logic [31:0] PADDR_XOR      = 32'h4000_0000;

  logic       i_clk = 1'b0;
  logic       i_reset_n;
  logic       i_flush_valid, i_fence_i, i_l2_req_fire;
  vaddr_t     i_l2_req_vaddr;
  paddr_t     i_l2_req_paddr;
  logic       o_pref_req_valid, i_pref_req_ready;
  paddr_t     o_pref_req_paddr;
  logic [1:0] o_pref_req_color;
  logic       i_pref_resp_valid;
  line_data_t i_pref_resp_data;
  logic       i_f0_search_valid;
  vaddr_t     i_f0_search_vaddr;
  logic       o_f1_hit, o_f1_working_hit;
  line_data_t o_f1_data;
  logic       o_ic_wr_valid, i_ic_wr_ready;
  vaddr_t     o_ic_wr_vaddr;
  line_data_t o_ic_wr_data;

  logic [31:0] lfsr;
  int          n_errors = 0;
  int          n_checks = 0;
  int          n_hits = 0;
  int          n_work = 0;
  int          cycle_cnt = 0;
  vaddr_t      last_next;  // Next line of the latest fire, steers searches
  // L2 model
  logic        resp_pend;
  int          resp_wait;
  paddr_t      resp_paddr;
  // Reference model state
  logic        m_dec_valid, m_fence_pend, m_buf_valid, m_f1_hit, m_f1_work, m_wr_busy;
  vaddr_t      m_dec_vaddr, m_eng_vaddr, m_buf_vaddr, m_wr_vaddr;
  paddr_t      m_dec_paddr, m_eng_paddr;
  line_data_t  m_buf_data, m_f1_data, m_wr_data;
  pref_state_e m_state;

  ic_pref_top #(.COLOR_W(2)) ic_pref_top_inst (.*);

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);  // Galois step
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Word i of a line is the line paddr XOR i
  function automatic line_data_t line_rule(input paddr_t pa);
    line_data_t d;
    for (int w = 0; w < 4; w++) begin
      d[w*32 +: 32] = pa ^ 32'(w);
    end
    return d;
  endfunction

  // Four pages, lines 0..6 plus the last line of the page
  function automatic vaddr_t rand_addr();
    logic [2:0]  idx;
    logic [7:0]  line_idx;
    logic [19:0] vpn;
    idx      = 3'(rand_bits(3));
    line_idx = (idx == 3'd7) ? 8'hff : {5'd0, idx};
    vpn      = 20'h40000 + 20'(rand_bits(2));
    return {vpn, line_idx, 4'(rand_bits(4))};
  endfunction

  task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // --------------------
  // Stimulus and models
  // --------------------
  task automatic drive_inputs();
    vaddr_t va;
    va                = rand_addr();
    i_l2_req_fire     = (rand_bits(2) == 0);
    i_l2_req_vaddr    = va;
    i_l2_req_paddr    = va ^ PADDR_XOR;
    i_flush_valid     = (rand_bits(4) == 0);
    i_fence_i         = (rand_bits(5) == 0);
    i_pref_req_ready  = (rand_bits(1) != 0);
    i_ic_wr_ready     = (rand_bits(1) != 0);
    i_f0_search_valid = (rand_bits(1) != 0);
    if (rand_bits(1) != 0) begin
      i_f0_search_vaddr = {last_next[31:4], 4'(rand_bits(4))};
    end else begin
      i_f0_search_vaddr = rand_addr();
    end
    if (i_l2_req_fire) last_next = {va[31:4], 4'h0} + 32'd16;
    // L2 answers 1 to 6 cycles after the transfer
    i_pref_resp_valid = 1'b0;
    if (resp_pend) begin
      if (resp_wait == 0) begin
        i_pref_resp_valid = 1'b1;
        i_pref_resp_data  = line_rule(resp_paddr);
        resp_pend         = 1'b0;
      end else begin
        resp_wait--;
      end
    end
    if (o_pref_req_valid && i_pref_req_ready) begin
      resp_pend  = 1'b1;
      resp_wait  = int'(rand_bits(3) % 6);
      resp_paddr = o_pref_req_paddr;
    end
  endtask

  task automatic check_outputs();
    compare("pref_req_valid", 128'(o_pref_req_valid), 128'(m_state == PrefReq));
    if (m_state == PrefReq) begin
      compare("pref_req_paddr", 128'(o_pref_req_paddr), 128'(m_eng_paddr));
      compare("pref_req_color", 128'(o_pref_req_color), 128'(m_eng_vaddr[13:12]));
    end
    compare("f1_hit", 128'(o_f1_hit), 128'(m_f1_hit));
    compare("f1_working_hit", 128'(o_f1_working_hit), 128'(m_f1_work));
    if (m_f1_hit) begin
      n_hits++;
      compare("f1_data", o_f1_data, m_f1_data);
    end
    if (m_f1_work) n_work++;
    compare("ic_wr_valid", 128'(o_ic_wr_valid), 128'(m_wr_busy));
    if (m_wr_busy) begin
      compare("ic_wr_vaddr", 128'(o_ic_wr_vaddr), 128'(m_wr_vaddr));
      compare("ic_wr_data", o_ic_wr_data, m_wr_data);
    end
  endtask

  // Next model state from the inputs sampled at the coming rising edge
  task automatic step_model();
    logic       xfer, busy, fill, take, buf_hit, busy_match, resp_hit, wr_clear;
    line_data_t fill_data;
    xfer       = (m_state == PrefReq) && i_pref_req_ready;
    busy       = (m_state == PrefResp);
    fill       = busy && i_pref_resp_valid;
    fill_data  = line_rule(m_eng_paddr);
    take       = i_l2_req_fire && !i_flush_valid && !i_fence_i &&
                 (i_l2_req_vaddr[11:4] != 8'hff);
    buf_hit    = i_f0_search_valid && m_buf_valid &&
                 (i_f0_search_vaddr[31:4] == m_buf_vaddr[31:4]);
    busy_match = i_f0_search_valid && busy && (i_f0_search_vaddr[31:4] == m_eng_vaddr[31:4]);
    resp_hit   = busy_match && fill;
    wr_clear   = m_wr_busy && i_ic_wr_ready && (m_buf_vaddr[31:4] == m_wr_vaddr[31:4]);

    m_f1_hit  = buf_hit || resp_hit;
    m_f1_work = busy_match && !fill && !buf_hit;
    m_f1_data = resp_hit ? fill_data : m_buf_data;

    if (!m_wr_busy && buf_hit) begin
      m_wr_busy  = 1'b1;
      m_wr_vaddr = m_buf_vaddr;
      m_wr_data  = m_buf_data;
    end else if (m_wr_busy && i_ic_wr_ready) begin
      m_wr_busy = 1'b0;
    end

    if (fill) begin
      m_buf_valid = 1'b1;
      m_buf_vaddr = m_eng_vaddr;
      m_buf_data  = fill_data;
    end else if (wr_clear) begin
      m_buf_valid = 1'b0;  // Line moved to the I-cache
    end

    case (m_state)
      PrefIdle: begin
        m_fence_pend = 1'b0;
        if (m_dec_valid) begin
          m_state     = PrefReq;
          m_eng_vaddr = m_dec_vaddr;
          m_eng_paddr = m_dec_paddr;
        end
      end
      PrefReq: begin
        if (xfer) begin
          m_state      = (i_fence_i || m_fence_pend) ? PrefDrain : PrefResp;
          m_fence_pend = 1'b0;
        end else if (i_fence_i) begin
          m_fence_pend = 1'b1;
        end
      end
      PrefResp: begin
        if (i_pref_resp_valid) m_state = PrefIdle;
        else if (i_fence_i) m_state = PrefDrain;
      end
      PrefDrain: if (i_pref_resp_valid) m_state = PrefIdle;  // Response dropped
      default: m_state = PrefIdle;
    endcase

    m_dec_valid = take;
    if (take) begin
      m_dec_vaddr = {i_l2_req_vaddr[31:4], 4'h0} + 32'd16;
      m_dec_paddr = {i_l2_req_paddr[31:4], 4'h0} + 32'd16;
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    lfsr              = 32'd69;
    i_reset_n         = 1'b0;
    i_flush_valid     = 1'b0;
    i_fence_i         = 1'b0;
    i_l2_req_fire     = 1'b0;
    i_l2_req_vaddr    = '0;
    i_l2_req_paddr    = '0;
    i_pref_req_ready  = 1'b0;
    i_pref_resp_valid = 1'b0;
    i_pref_resp_data  = '0;
    i_f0_search_valid = 1'b0;
    i_f0_search_vaddr = '0;
    i_ic_wr_ready     = 1'b0;
    last_next         = 32'h4000_0010;
    resp_pend         = 1'b0;
    resp_wait         = 0;
    resp_paddr        = '0;
    m_state           = PrefIdle;
    {m_dec_valid, m_fence_pend, m_buf_valid, m_f1_hit, m_f1_work, m_wr_busy} = '0;
    {m_dec_vaddr, m_eng_vaddr, m_buf_vaddr, m_wr_vaddr, m_dec_paddr, m_eng_paddr} = '0;
    {m_buf_data, m_f1_data, m_wr_data} = '0;

    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // Outputs checked on the falling edge, before new inputs go out
    for (int c = 0; c < NUM_CYCLES; c++) begin
      check_outputs();
      drive_inputs();
      step_model();
      @(negedge i_clk);
    end

    if (n_hits == 0 || n_work == 0) begin
      n_errors++;
      $display("Stimulus never produced both a buffer hit and a working hit");
    end
    n_errors = n_errors + ic_pref_top_inst.ic_pref_chk_inst.n_fail;
    $display("Checks: %0d, errors: %0d, hits: %0d, working hits: %0d",
             n_checks, n_errors, n_hits, n_work);
    if (n_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- testbench/ic_pref_chk.sv
// Protocol assertions for the next-line prefetcher
// Bound to the top level to watch the L2, search and I-cache ports

`timescale 1ns/1ns

module ic_pref_chk (
  input logic                    i_clk,
  input logic                    i_reset_n,
  input logic                    i_req_valid,
  input logic                    i_req_ready,
  input ic_pref_pkg::paddr_t     i_req_paddr,
  input logic                    i_resp_valid,
  input logic                    i_f1_hit,
  input logic                    i_f1_working_hit,
  input logic                    i_wr_valid,
  input logic                    i_wr_ready,
  input ic_pref_pkg::vaddr_t     i_wr_vaddr,
  input ic_pref_pkg::line_data_t i_wr_data
);

  int   n_fail = 0;
  logic r_await;  // Request taken by L2, response not seen yet

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_await <= 1'b0;
    end else if (i_req_valid && i_req_ready) begin
      r_await <= 1'b1;
    end else if (i_resp_valid) begin
      r_await <= 1'b0;
    end
  end

  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_req_valid && !i_req_ready |=> i_req_valid)
    else begin
      $error("prefetch request valid dropped before ready");
      n_fail++;
    end

  a_req_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_req_valid && !i_req_ready |=> $stable(i_req_paddr))
    else begin
      $error("prefetch request address changed while waiting");
      n_fail++;
    end

  // Cache write holds valid, vaddr and data under back-pressure
  a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid && !i_wr_ready |=> i_wr_valid && $stable(i_wr_vaddr) && $stable(i_wr_data))
    else begin
      $error("cache write not held while ready is low");
      n_fail++;
    end

  a_hit_excl: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_f1_hit && i_f1_working_hit))
    else begin
      $error("hit and working hit high together");
      n_fail++;
    end

  a_no_req_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(r_await && i_req_valid))
    else begin
      $error("request issued while a response is awaited");
      n_fail++;
    end

endmodule

bind ic_pref_top ic_pref_chk ic_pref_chk_inst (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_req_valid      (o_pref_req_valid),
  .i_req_ready      (i_pref_req_ready),
  .i_req_paddr      (o_pref_req_paddr),
  .i_resp_valid     (i_pref_resp_valid),
  .i_f1_hit         (o_f1_hit),
  .i_f1_working_hit (o_f1_working_hit),
  .i_wr_valid       (o_ic_wr_valid),
  .i_wr_ready       (i_ic_wr_ready),
  .i_wr_vaddr       (o_ic_wr_vaddr),
  .i_wr_data        (o_ic_wr_data)
);

//--- rtl/ic_pref_top.sv
// Next-line instruction prefetcher top level
// Decode, prefetch engine and line buffer

`timescale 1ns/1ns

module ic_pref_top #(
  parameter int COLOR_W = 2
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  logic                            i_flush_valid,
  input  logic                            i_fence_i,
  // Normal fetch miss to L2
  input  logic                            i_l2_req_fire,
  input  ic_pref_pkg::vaddr_t             i_l2_req_vaddr,
  input  ic_pref_pkg::paddr_t             i_l2_req_paddr,
  // Prefetch request and response
  output logic                            o_pref_req_valid,
  input  logic                            i_pref_req_ready,
  output ic_pref_pkg::paddr_t             o_pref_req_paddr,
  output logic [((COLOR_W > 0) ? COLOR_W : 1)-1:0] o_pref_req_color,
  input  logic                            i_pref_resp_valid,
  input  ic_pref_pkg::line_data_t         i_pref_resp_data,
  // Fetch search
  input  logic                            i_f0_search_valid,
  input  ic_pref_pkg::vaddr_t             i_f0_search_vaddr,
  output logic                            o_f1_hit,
  output ic_pref_pkg::line_data_t         o_f1_data,
  output logic                            o_f1_working_hit,
  // I-cache write
  output logic                            o_ic_wr_valid,
  input  logic                            i_ic_wr_ready,
  output ic_pref_pkg::vaddr_t             o_ic_wr_vaddr,
  output ic_pref_pkg::line_data_t         o_ic_wr_data
);

  import ic_pref_pkg::*;

  pref_cand_t cand;
  logic       fill_valid;
  vaddr_t     fill_vaddr;
  logic       busy_valid;
  vaddr_t     busy_vaddr;

  ic_pref_req_decode ic_pref_req_decode_inst (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_flush_valid  (i_flush_valid),
    .i_fence_i      (i_fence_i),
    .i_l2_req_fire  (i_l2_req_fire),
    .i_l2_req_vaddr (i_l2_req_vaddr),
    .i_l2_req_paddr (i_l2_req_paddr),
    .o_cand         (cand)
  );

  ic_pref_engine #(
    .COLOR_W (COLOR_W)
  ) ic_pref_engine_inst (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_fence_i         (i_fence_i),
    .i_cand            (cand),
    .i_pref_req_ready  (i_pref_req_ready),
    .i_pref_resp_valid (i_pref_resp_valid),
    .o_pref_req_valid  (o_pref_req_valid),
    .o_pref_req_paddr  (o_pref_req_paddr),
    .o_pref_req_color  (o_pref_req_color),
    .o_fill_valid      (fill_valid),
    .o_fill_vaddr      (fill_vaddr),
    .o_busy_valid      (busy_valid),
    .o_busy_vaddr      (busy_vaddr)
  );

  // Response data goes straight to the buffer
  ic_pref_buffer ic_pref_buffer_inst (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_fill_valid      (fill_valid),
    .i_fill_vaddr      (fill_vaddr),
    .i_resp_data       (i_pref_resp_data),
    .i_busy_valid      (busy_valid),
    .i_busy_vaddr      (busy_vaddr),
    .i_f0_search_valid (i_f0_search_valid),
    .i_f0_search_vaddr (i_f0_search_vaddr),
    .i_ic_wr_ready     (i_ic_wr_ready),
    .o_f1_hit          (o_f1_hit),
    .o_f1_data         (o_f1_data),
    .o_f1_working_hit  (o_f1_working_hit),
    .o_ic_wr_valid     (o_ic_wr_valid),
    .o_ic_wr_vaddr     (o_ic_wr_vaddr),
    .o_ic_wr_data      (o_ic_wr_data)
  );

endmodule

//--- rtl/ic_pref_buffer.sv
// Prefetch line buffer
// Holds one prefetched line, answers f0 searches in f1 and writes hits to the I-cache

`timescale 1ns/1ns

module ic_pref_buffer (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_fill_valid,
  input  ic_pref_pkg::vaddr_t      i_fill_vaddr,
  input  ic_pref_pkg::line_data_t  i_resp_data,
  input  logic                     i_busy_valid,
  input  ic_pref_pkg::vaddr_t      i_busy_vaddr,
  input  logic                     i_f0_search_valid,
  input  ic_pref_pkg::vaddr_t      i_f0_search_vaddr,
  input  logic                     i_ic_wr_ready,
  output logic                     o_f1_hit,
  output ic_pref_pkg::line_data_t  o_f1_data,
  output logic                     o_f1_working_hit,
  output logic                     o_ic_wr_valid,
  output ic_pref_pkg::vaddr_t      o_ic_wr_vaddr,
  output ic_pref_pkg::line_data_t  o_ic_wr_data
);

  import ic_pref_pkg::*;

  logic        r_buf_valid;
  vaddr_t      r_buf_vaddr;
  line_data_t  r_buf_data;

  wr_state_e   r_wr_state;
  vaddr_t      r_wr_vaddr;
  line_data_t  r_wr_data;

  fetch_addr_u w_srch;
  fetch_addr_u w_buf;
  fetch_addr_u w_busy;
  fetch_addr_u w_wr;
  logic        w_buf_hit;
  logic        w_busy_match;
  logic        w_resp_hit;
  logic        w_wr_xfer;

  assign w_srch = i_f0_search_vaddr;
  assign w_buf  = r_buf_vaddr;
  assign w_busy = i_busy_vaddr;
  assign w_wr   = r_wr_vaddr;

  // --------------------
  // Line storage
  // --------------------
  assign w_wr_xfer = o_ic_wr_valid & i_ic_wr_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_buf_valid <= 1'b0;
    end else if (i_fill_valid) begin
      r_buf_valid <= 1'b1;
    end else if (w_wr_xfer && (w_buf.line.line_no == w_wr.line.line_no)) begin
      r_buf_valid <= 1'b0;  // Line now lives in the I-cache
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_valid) begin
      r_buf_vaddr <= i_fill_vaddr;
      r_buf_data  <= i_resp_data;
    end
  end

  // --------------------
  // f0 search, f1 result
  // --------------------
  assign w_buf_hit    = i_f0_search_valid & r_buf_valid &
                        (w_srch.line.line_no == w_buf.line.line_no);
  assign w_busy_match = i_f0_search_valid & i_busy_valid &
                        (w_srch.line.line_no == w_busy.line.line_no);
  assign w_resp_hit   = w_busy_match & i_fill_valid;  // Line arrives this cycle

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_f1_hit         <= 1'b0;
      o_f1_working_hit <= 1'b0;
    end else begin
      o_f1_hit         <= w_buf_hit | w_resp_hit;
      o_f1_working_hit <= w_busy_match & ~i_fill_valid & ~w_buf_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    o_f1_data <= w_resp_hit ? i_resp_data : r_buf_data;
  end

  // --------------------
  // I-cache write back
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_state <= WrIdle;
    end else begin
      case (r_wr_state)
        WrIdle: if (w_buf_hit) r_wr_state <= WrWait;
        WrWait: if (i_ic_wr_ready) r_wr_state <= WrIdle;
        default: r_wr_state <= WrIdle;
      endcase
    end
  end

  // Snapshot keeps the write stable across a refill
  always_ff @(posedge i_clk) begin
    if ((r_wr_state == WrIdle) && w_buf_hit) begin
      r_wr_vaddr <= r_buf_vaddr;
      r_wr_data  <= r_buf_data;
    end
  end

  assign o_ic_wr_valid = (r_wr_state == WrWait);
  assign o_ic_wr_vaddr = r_wr_vaddr;
  assign o_ic_wr_data  = r_wr_data;

endmodule

//--- rtl/ic_pref_engine.sv
// Prefetch engine
// Issues one next-line request to L2 and tracks its response, fence.i drains it

`timescale 1ns/1ns

module ic_pref_engine #(
  parameter int COLOR_W = 2
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  logic                            i_fence_i,
  input  ic_pref_pkg::pref_cand_t         i_cand,
  input  logic                            i_pref_req_ready,
  input  logic                            i_pref_resp_valid,
  output logic                            o_pref_req_valid,
  output ic_pref_pkg::paddr_t             o_pref_req_paddr,
  output logic [((COLOR_W > 0) ? COLOR_W : 1)-1:0] o_pref_req_color,
  output logic                            o_fill_valid,
  output ic_pref_pkg::vaddr_t             o_fill_vaddr,
  output logic                            o_busy_valid,
  output ic_pref_pkg::vaddr_t             o_busy_vaddr
);

  import ic_pref_pkg::*;

  pref_state_e r_state;
  vaddr_t      r_vaddr;
  paddr_t      r_paddr;
  logic        r_fence_pend;  // fence.i seen while request waits
  logic        w_req_xfer;
  logic        w_kill;
  fetch_addr_u w_req_addr;

  assign w_req_xfer = o_pref_req_valid & i_pref_req_ready;
  assign w_kill     = i_fence_i | r_fence_pend;

  // --------------------
  // State machine
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= PrefIdle;
      r_fence_pend <= 1'b0;
    end else begin
      case (r_state)
        PrefIdle: begin
          r_fence_pend <= 1'b0;
          if (i_cand.valid) r_state <= PrefReq;
        end
        PrefReq: begin
          // Request is held until L2 takes it, fence.i only redirects the outcome
          if (w_req_xfer) begin
            r_state      <= w_kill ? PrefDrain : PrefResp;
            r_fence_pend <= 1'b0;
          end else if (i_fence_i) begin
            r_fence_pend <= 1'b1;
          end
        end
        PrefResp: begin
          if (i_pref_resp_valid) begin
            r_state <= PrefIdle;
          end else if (i_fence_i) begin
            r_state <= PrefDrain;
          end
        end
        PrefDrain: begin
          if (i_pref_resp_valid) r_state <= PrefIdle;  // Data dropped
        end
        default: r_state <= PrefIdle;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == PrefIdle) && i_cand.valid) begin
      r_vaddr <= i_cand.vaddr;
      r_paddr <= i_cand.paddr;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign o_pref_req_valid = (r_state == PrefReq);
  assign o_pref_req_paddr = r_paddr;

  assign w_req_addr = r_vaddr;

  generate
    if (COLOR_W == 0) begin : g_no_color
      assign o_pref_req_color = '0;
    end else begin : g_color
      assign o_pref_req_color = w_req_addr.page.vpn[COLOR_W-1:0];  // vaddr bits from 12 up
    end
  endgenerate

  assign o_busy_valid = (r_state == PrefResp);
  assign o_busy_vaddr = r_vaddr;
  assign o_fill_valid = o_busy_valid & i_pref_resp_valid;
  assign o_fill_vaddr = r_vaddr;

endmodule

//--- rtl/ic_pref_req_decode.sv
// Prefetch request decode
// Turns an L2 fetch miss into a registered next-line candidate

`timescale 1ns/1ns

module ic_pref_req_decode (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_flush_valid,
  input  logic                   i_fence_i,
  input  logic                   i_l2_req_fire,
  input  ic_pref_pkg::vaddr_t    i_l2_req_vaddr,
  input  ic_pref_pkg::paddr_t    i_l2_req_paddr,
  output ic_pref_pkg::pref_cand_t o_cand
);

  import ic_pref_pkg::*;

  fetch_addr_u w_fire_addr;
  logic        w_cross_page;
  logic        w_take;
  vaddr_t      w_next_vaddr;
  paddr_t      w_next_paddr;

  logic        r_valid;
  vaddr_t      r_vaddr;
  paddr_t      r_paddr;

  assign w_fire_addr = i_l2_req_vaddr;

  // Next line leaves the page when this one is the last of it
  assign w_cross_page = &w_fire_addr.page.page_off[PAGE_OFF_W-1:OFFSET_W];

  assign w_next_vaddr = {w_fire_addr.line.line_no, {OFFSET_W{1'b0}}} + vaddr_t'(LINE_BYTES);
  assign w_next_paddr = {i_l2_req_paddr[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}
                        + paddr_t'(LINE_BYTES);

  assign w_take = i_l2_req_fire & ~i_flush_valid & ~i_fence_i & ~w_cross_page;

  // One-cycle candidate strobe
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= w_take;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_take) begin
      r_vaddr <= w_next_vaddr;
      r_paddr <= w_next_paddr;
    end
  end

  assign o_cand.valid = r_valid;
  assign o_cand.vaddr = r_vaddr;
  assign o_cand.paddr = r_paddr;

endmodule

//--- rtl/ic_pref_pkg.sv
// Next-line instruction prefetcher, shared definitions
// Address widths, line geometry, fetch address views and state encodings

package ic_pref_pkg;

  // --------------------
  // Widths and geometry
  // --------------------
  localparam int VADDR_W    = 32;
  localparam int PADDR_W    = 32;
  localparam int LINE_BYTES = 16;
  localparam int OFFSET_W   = $clog2(LINE_BYTES);
  localparam int LINE_W     = LINE_BYTES * 8;
  localparam int PAGE_OFF_W = 12;  // 4 KB pages

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [LINE_W-1:0]  line_data_t;

  // --------------------
  // Fetch address views
  // --------------------
  typedef struct packed {
    logic [VADDR_W-PAGE_OFF_W-1:0] vpn;
    logic [PAGE_OFF_W-1:0]         page_off;
  } page_view_t;

  typedef struct packed {
    logic [VADDR_W-OFFSET_W-1:0] line_no;
    logic [OFFSET_W-1:0]         offset;
  } line_view_t;

  // Same address word, page split or line split
  typedef union packed {
    page_view_t page;
    line_view_t line;
  } fetch_addr_u;

  // Next-line candidate from decode to engine
  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
    paddr_t paddr;
  } pref_cand_t;

  // --------------------
  // State encodings
  // --------------------
  typedef enum logic [1:0] {
    PrefIdle,
    PrefReq,
    PrefResp,
    PrefDrain  // Response still owed, data discarded
  } pref_state_e;

  typedef enum logic {
    WrIdle,
    WrWait
  } wr_state_e;

endpackage
